// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the fetch front end testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_fetch_frontend

verilator --binary --timing --assert -f src.f --top-module "$TOP" -o "$TOP"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0

// File: source/cacheline_adapter.sv
`timescale 1ns/1ps

module cacheline_adapter (
    input  logic             clk,
    input  logic             rst,

    // burst read return
    input  fetch_pkg::addr_t bmem_raddr,
    input  fetch_pkg::beat_t bmem_rdata,
    input  logic             bmem_rvalid,

    // assembled line towards the cache
    output fetch_pkg::line_t line_data,
    output fetch_pkg::addr_t line_addr,
    output logic             line_valid
);

    localparam int COUNT_BITS = $clog2(fetch_pkg::BEATS_PER_LINE);
    localparam int LINE_W     = $bits(fetch_pkg::line_t);
    localparam int BEAT_W     = $bits(fetch_pkg::beat_t);

    logic [COUNT_BITS-1:0] beat_count;
    logic                  first_beat;
    logic                  last_beat;

    assign first_beat = (beat_count == '0);
    assign last_beat  = (beat_count == COUNT_BITS'(fetch_pkg::BEATS_PER_LINE - 1));

    // beat counter and completion pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_count <= '0;
            line_valid <= 1'b0;
        end else begin
            line_valid <= bmem_rvalid && last_beat;
            if (bmem_rvalid) begin
                if (last_beat) begin
                    beat_count <= '0;
                end else begin
                    beat_count <= beat_count + 1'b1;
                end
            end
        end
    end

    // new beats enter at the top, so beat 0 ends up in the low bytes
    always_ff @(posedge clk) begin
        if (bmem_rvalid) begin
            line_data <= {bmem_rdata, line_data[LINE_W-1:BEAT_W]};
            if (first_beat) begin
                line_addr <= bmem_raddr;
            end
        end
    end

endmodule : cacheline_adapter

// File: source/fetch_frontend.sv
`timescale 1ns/1ps

module fetch_frontend #(
    parameter fetch_pkg::addr_t RESET_PC    = 32'h1eceb000,
    parameter int               CACHE_SETS  = 16,
    parameter int               QUEUE_DEPTH = 8
) (
    input  logic              clk,
    input  logic              rst,

    // burst memory port
    output fetch_pkg::addr_t  bmem_addr,
    output logic              bmem_read,
    input  logic              bmem_ready,
    input  fetch_pkg::addr_t  bmem_raddr,
    input  fetch_pkg::beat_t  bmem_rdata,
    input  logic              bmem_rvalid,

    // consumer side
    output logic              instr_valid,
    output fetch_pkg::instr_t instr_rdata,
    output fetch_pkg::addr_t  instr_pc,
    input  logic              instr_dequeue
);

    // pc stage to cache
    fetch_pkg::addr_t  req_addr;
    logic              req_valid;
    fetch_pkg::instr_t resp_rdata;
    logic              resp_valid;

    // adapter to cache
    fetch_pkg::line_t  line_data;
    fetch_pkg::addr_t  line_addr;
    logic              line_valid;

    logic              queue_full;
    logic              queue_empty;

    fetch_pc #(
        .RESET_PC   (RESET_PC)
    ) fetch_pc_inst (
        .clk        (clk),
        .rst        (rst),
        .full       (queue_full),
        .resp_valid (resp_valid),
        .req_addr   (req_addr),
        .req_valid  (req_valid)
    );

    icache #(
        .CACHE_SETS (CACHE_SETS)
    ) icache_inst (
        .clk        (clk),
        .rst        (rst),
        .req_addr   (req_addr),
        .req_valid  (req_valid),
        .resp_rdata (resp_rdata),
        .resp_valid (resp_valid),
        .bmem_addr  (bmem_addr),
        .bmem_read  (bmem_read),
        .bmem_ready (bmem_ready),
        .line_data  (line_data),
        .line_addr  (line_addr),
        .line_valid (line_valid)
    );

    cacheline_adapter cacheline_adapter_inst (
        .clk         (clk),
        .rst         (rst),
        .bmem_raddr  (bmem_raddr),
        .bmem_rdata  (bmem_rdata),
        .bmem_rvalid (bmem_rvalid),
        .line_data   (line_data),
        .line_addr   (line_addr),
        .line_valid  (line_valid)
    );

    // req_addr still holds the pc of the returning word
    instr_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) instr_queue_inst (
        .clk       (clk),
        .rst       (rst),
        .enq_instr (resp_rdata),
        .enq_pc    (req_addr),
        .enqueue   (resp_valid),
        .dequeue   (instr_dequeue),
        .deq_instr (instr_rdata),
        .deq_pc    (instr_pc),
        .full      (queue_full),
        .empty     (queue_empty)
    );

    assign instr_valid = !queue_empty;

endmodule : fetch_frontend

// File: source/fetch_pc.sv
`timescale 1ns/1ps

module fetch_pc #(
    parameter fetch_pkg::addr_t RESET_PC = 32'h1eceb000
) (
    input  logic             clk,
    input  logic             rst,

    input  logic             full,
    input  logic             resp_valid,

    output fetch_pkg::addr_t req_addr,
    output logic             req_valid
);

    // a request is in flight until the cache answers
    logic pending;
    logic issue;

    // only one outstanding request, and never into a full queue
    assign issue = !pending && !full;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_addr  <= RESET_PC;
            req_valid <= 1'b0;
            pending   <= 1'b0;
        end else begin
            // single-cycle request strobe
            req_valid <= issue;

            if (issue) begin
                pending <= 1'b1;
            end else if (resp_valid) begin
                // req_addr was the pc of the word just returned
                pending  <= 1'b0;
                req_addr <= req_addr + 32'd4;
            end
        end
    end

endmodule : fetch_pc

// File: source/fetch_pkg.sv
package fetch_pkg;

    // basic datapath widths
    typedef logic [31:0]  addr_t;
    typedef logic [31:0]  instr_t;

    // one beat of the burst memory port
    typedef logic [63:0]  beat_t;

    // a full cache line, 8 words
    typedef logic [255:0] line_t;

    // line geometry
    localparam int BEATS_PER_LINE = 4;
    localparam int OFFSET_BITS    = 5;
    localparam int WORDS_PER_LINE = $bits(line_t) / $bits(instr_t);

    // cache controller states
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL
    } cache_state_t;

endpackage : fetch_pkg

// File: source/icache.sv
`timescale 1ns/1ps

module icache #(
    parameter int CACHE_SETS = 16
) (
    input  logic             clk,
    input  logic             rst,

    // fetch side
    input  fetch_pkg::addr_t  req_addr,
    input  logic              req_valid,
    output fetch_pkg::instr_t resp_rdata,
    output logic              resp_valid,

    // memory request side
    output fetch_pkg::addr_t  bmem_addr,
    output logic              bmem_read,
    input  logic              bmem_ready,

    // refill from the cacheline adapter
    input  fetch_pkg::line_t  line_data,
    input  fetch_pkg::addr_t  line_addr,
    input  logic              line_valid
);

    localparam int INDEX_BITS = $clog2(CACHE_SETS);
    localparam int TAG_BITS   = 32 - fetch_pkg::OFFSET_BITS - INDEX_BITS;
    localparam int WORD_BITS  = $clog2(fetch_pkg::WORDS_PER_LINE);
    localparam int IDX_LO     = fetch_pkg::OFFSET_BITS;
    localparam int TAG_LO     = fetch_pkg::OFFSET_BITS + INDEX_BITS;

    fetch_pkg::cache_state_t state;

    // per-set storage
    logic [TAG_BITS-1:0]    tag_array  [CACHE_SETS];
    fetch_pkg::line_t       data_array [CACHE_SETS];
    logic [CACHE_SETS-1:0]  valid_bits;

    // address of the request being served
    fetch_pkg::addr_t       addr_q;

    logic [INDEX_BITS-1:0]  lookup_index;
    logic [TAG_BITS-1:0]    lookup_tag;
    logic [WORD_BITS-1:0]   word_sel;
    logic [INDEX_BITS-1:0]  fill_index;
    logic                   hit;

    assign lookup_index = addr_q[TAG_LO-1:IDX_LO];
    assign lookup_tag   = addr_q[31:TAG_LO];
    assign word_sel     = addr_q[IDX_LO-1:2];
    assign fill_index   = line_addr[TAG_LO-1:IDX_LO];

    assign hit = valid_bits[lookup_index] && (tag_array[lookup_index] == lookup_tag);

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= fetch_pkg::IDLE;
            resp_valid <= 1'b0;
            bmem_read  <= 1'b0;
            valid_bits <= '0;
        end else begin
            resp_valid <= 1'b0;

            // read request is accepted once ready is seen
            if (bmem_read && bmem_ready) begin
                bmem_read <= 1'b0;
            end

            case (state)
                fetch_pkg::IDLE: begin
                    if (req_valid) begin
                        state <= fetch_pkg::LOOKUP;
                    end
                end
                fetch_pkg::LOOKUP: begin
                    if (hit) begin
                        resp_valid <= 1'b1;
                        state      <= fetch_pkg::IDLE;
                    end else begin
                        bmem_read <= 1'b1;
                        state     <= fetch_pkg::REFILL;
                    end
                end
                fetch_pkg::REFILL: begin
                    // retry the lookup once the line is in
                    if (line_valid) begin
                        valid_bits[fill_index] <= 1'b1;
                        state                  <= fetch_pkg::LOOKUP;
                    end
                end
                default: begin
                    state <= fetch_pkg::IDLE;
                end
            endcase
        end
    end

    // payload and arrays
    always_ff @(posedge clk) begin
        if (state == fetch_pkg::IDLE && req_valid) begin
            addr_q <= req_addr;
        end

        if (state == fetch_pkg::LOOKUP) begin
            if (hit) begin
                resp_rdata <= data_array[lookup_index][32 * word_sel +: 32];
            end else begin
                // line-aligned miss address
                bmem_addr <= {addr_q[31:IDX_LO], {fetch_pkg::OFFSET_BITS{1'b0}}};
            end
        end

        if (state == fetch_pkg::REFILL && line_valid) begin
            tag_array[fill_index]  <= line_addr[31:TAG_LO];
            data_array[fill_index] <= line_data;
        end
    end

endmodule : icache

// File: source/instr_queue.sv
`timescale 1ns/1ps

module instr_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic              clk,
    input  logic              rst,

    input  fetch_pkg::instr_t enq_instr,
    input  fetch_pkg::addr_t  enq_pc,
    input  logic              enqueue,
    input  logic              dequeue,

    output fetch_pkg::instr_t deq_instr,
    output fetch_pkg::addr_t  deq_pc,
    output logic              full,
    output logic              empty
);

    localparam int PTR_BITS = $clog2(QUEUE_DEPTH);

    fetch_pkg::instr_t instr_mem [QUEUE_DEPTH];
    fetch_pkg::addr_t  pc_mem    [QUEUE_DEPTH];

    // msb is the wrap bit
    logic [PTR_BITS:0] wr_ptr;
    logic [PTR_BITS:0] rd_ptr;

    logic do_enq;
    logic do_deq;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PTR_BITS] != rd_ptr[PTR_BITS]) &&
                   (wr_ptr[PTR_BITS-1:0] == rd_ptr[PTR_BITS-1:0]);

    // dequeue on empty is dropped
    assign do_enq = enqueue && !full;
    assign do_deq = dequeue && !empty;

    // head entry
    assign deq_instr = instr_mem[rd_ptr[PTR_BITS-1:0]];
    assign deq_pc    = pc_mem[rd_ptr[PTR_BITS-1:0]];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_deq) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            instr_mem[wr_ptr[PTR_BITS-1:0]] <= enq_instr;
            pc_mem[wr_ptr[PTR_BITS-1:0]]    <= enq_pc;
        end
    end

endmodule : instr_queue

// File: src.f
source/fetch_pkg.sv
source/fetch_pc.sv
source/icache.sv
source/cacheline_adapter.sv
source/instr_queue.sv
source/fetch_frontend.sv
testbench/tb_fetch_frontend.sv

// File: testbench/tb_fetch_frontend.sv
`timescale 1ns/1ps

module tb_fetch_frontend;

    localparam fetch_pkg::addr_t RESET_PC    = 32'h1eceb000;
    localparam int               CACHE_SETS  = 16;
    localparam int               QUEUE_DEPTH = 8;
    localparam int               RESET_CYCLES   = 10;
    localparam int               NUM_INSTR      = 240;
    localparam int               TIMEOUT_CYCLES = 20000;
    localparam int               SETTLE_CYCLES  = 200;

    logic              clk;
    logic              rst;
    fetch_pkg::addr_t  bmem_addr;
    logic              bmem_read;
    logic              bmem_ready;
    fetch_pkg::addr_t  bmem_raddr;
    fetch_pkg::beat_t  bmem_rdata;
    logic              bmem_rvalid;
    logic              instr_valid;
    fetch_pkg::instr_t instr_rdata;
    fetch_pkg::addr_t  instr_pc;
    logic              instr_dequeue;

    // one counter per process
    int err_reset;
    int err_data;
    int err_mem;
    int err_flow;
    int checked;
    logic consumer_stop;
    fetch_pkg::addr_t expected_pc;
    fetch_pkg::addr_t line_log [$];

    fetch_frontend #(
        .RESET_PC    (RESET_PC),
        .CACHE_SETS  (CACHE_SETS),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) fetch_frontend_inst (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr     (bmem_addr),
        .bmem_read     (bmem_read),
        .bmem_ready    (bmem_ready),
        .bmem_raddr    (bmem_raddr),
        .bmem_rdata    (bmem_rdata),
        .bmem_rvalid   (bmem_rvalid),
        .instr_valid   (instr_valid),
        .instr_rdata   (instr_rdata),
        .instr_pc      (instr_pc),
        .instr_dequeue (instr_dequeue)
    );

    always #10 clk = ~clk;

    // expected instruction word at a byte address
    function automatic fetch_pkg::instr_t ref_instr(input fetch_pkg::addr_t addr);
        logic [31:0] x;
        x = addr * 32'h9e3779b1;
        return x ^ {x[15:0], x[31:16]} ^ 32'h00000013;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // one line read: ready after a random delay, then four beats with gaps
    task automatic serve_line();
        fetch_pkg::addr_t line_base;
        fetch_pkg::addr_t next_line;
        line_base = bmem_addr;
        next_line = {RESET_PC[31:5], 5'b0} + 32'(32 * line_log.size());
        assert (line_base[4:0] == 5'b0) else begin
            err_mem++;
            $display("Error miss_align: expected %h, actual %h", 5'b0, line_base[4:0]);
        end
        assert (line_base == next_line) else begin
            err_mem++;
            $display("Error miss_order: expected %h, actual %h", next_line, line_base);
        end
        repeat ($urandom % 4) next_cycle();
        bmem_ready = 1'b1;
        next_cycle();
        bmem_ready = 1'b0;
        line_log.push_back(line_base);
        for (int k = 0; k < fetch_pkg::BEATS_PER_LINE; k++) begin
            repeat ($urandom % 3) next_cycle();
            bmem_raddr  = line_base;
            bmem_rdata  = {ref_instr(line_base + 32'(8 * k + 4)),
                           ref_instr(line_base + 32'(8 * k))};
            bmem_rvalid = 1'b1;
            next_cycle();
            bmem_rvalid = 1'b0;
        end
    endtask

    initial begin : memory_model
        forever begin
            next_cycle();
            if (bmem_read) begin
                serve_line();
            end
        end
    end

    // random drain runs mixed with long stalls
    initial begin : consumer
        int   run_len;
        logic seen_valid;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        forever begin
            if ($urandom % 6 == 0) begin
                run_len       = 20 + int'($urandom % 30);
                seen_valid    = 1'b0;
                instr_dequeue = 1'b0;
                repeat (run_len) begin
                    next_cycle();
                    if (seen_valid) begin
                        assert (instr_valid) else begin
                            err_flow++;
                            $display("instr_valid dropped during a stall with no dequeue");
                        end
                    end
                    seen_valid = seen_valid || instr_valid;
                end
            end else begin
                run_len = 5 + int'($urandom % 20);
                repeat (run_len) begin
                    instr_dequeue = !consumer_stop && ($urandom % 4 != 0);
                    next_cycle();
                end
            end
        end
    end

    // compare every dequeued pair mid-cycle
    initial begin : compare_pairs
        expected_pc = RESET_PC;
        forever begin
            @(negedge clk);
            if (!rst && instr_valid && instr_dequeue) begin
                assert (instr_pc == expected_pc) else begin
                    err_data++;
                    $display("Error pc_order: expected %h, actual %h", expected_pc, instr_pc);
                end
                assert (instr_rdata == ref_instr(expected_pc)) else begin
                    err_data++;
                    $display("Error instr_data: expected %h, actual %h",
                             ref_instr(expected_pc), instr_rdata);
                end
                expected_pc = expected_pc + 32'd4;
                checked++;
            end
        end
    end

    initial begin : main
        int               cycles;
        int               total;
        fetch_pkg::addr_t last_pc;
        int               expected_lines;
        clk           = 1'b0;
        rst           = 1'b1;
        bmem_ready    = 1'b0;
        bmem_raddr    = '0;
        bmem_rdata    = '0;
        bmem_rvalid   = 1'b0;
        instr_dequeue = 1'b0;
        consumer_stop = 1'b0;
        err_reset     = 0;
        err_data      = 0;
        err_mem       = 0;
        err_flow      = 0;
        checked       = 0;
        void'($urandom(32'h350d));

        // reset state, also one cycle past release
        for (int i = 0; i <= RESET_CYCLES; i++) begin
            next_cycle();
            assert (!instr_valid && !bmem_read) else begin
                err_reset++;
                $display("Error reset_state: expected %b, actual %b",
                         2'b00, {instr_valid, bmem_read});
            end
            if (i == RESET_CYCLES - 1) begin
                rst = 1'b0;
            end
        end

        cycles = 0;
        while (checked < NUM_INSTR && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end

        if (checked < NUM_INSTR) begin
            $display("timeout after %0d cycles with only %0d instructions dequeued",
                     cycles, checked);
            $display("TESTS FAILED");
        end else begin
            // let the queue fill so fetch comes to rest
            consumer_stop = 1'b1;
            repeat (SETTLE_CYCLES) @(posedge clk);
            last_pc        = RESET_PC + 32'(4 * (checked + QUEUE_DEPTH - 1));
            expected_lines = int'((last_pc >> 5) - (RESET_PC >> 5)) + 1;
            assert (line_log.size() == expected_lines) else begin
                err_mem++;
                $display("Error miss_count: expected %0d, actual %0d",
                         expected_lines, line_log.size());
            end
            total = err_reset + err_data + err_mem + err_flow;
            $display("checked %0d instr, %0d line reads, errors: reset %0d data %0d mem %0d flow %0d",
                     checked, line_log.size(), err_reset, err_data, err_mem, err_flow);
            if (total == 0) begin
                $display("TESTS PASSED");
            end else begin
                $display("TESTS FAILED");
            end
        end
        $finish;
    end

endmodule : tb_fetch_frontend
